/* Makefile */
BUILD := obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f list.f --top-module tb_afu

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f list.f --top-module tb_afu -Mdir $(BUILD) -o tb_afu
	$(BUILD)/tb_afu | tee sim.log
	grep -qx "TEST PASS" sim.log

clean:
	rm -rf $(BUILD) sim.log

/* hw/afu_pkg.sv */
package afu_pkg;

  typedef logic [63:0] line_t;
  typedef logic [31:0] host_addr_t;
  typedef logic [15:0] lmem_addr_t;  // Also line count and tag
  typedef logic [15:0] mmio_addr_t;

  typedef enum logic [1:0] {
    CMD_NONE      = 2'd0,
    CMD_MEM_READ  = 2'd1,
    CMD_MEM_WRITE = 2'd2
  } cmd_e;

  // Encodings line up with cmd_e
  typedef enum logic [1:0] {
    ST_IDLE      = 2'd0,
    ST_MEM_READ  = 2'd1,
    ST_MEM_WRITE = 2'd2
  } state_e;

  localparam mmio_addr_t MMIO_AFU_ID_L = 16'h0002;
  localparam mmio_addr_t MMIO_AFU_ID_H = 16'h0004;
  localparam mmio_addr_t MMIO_CMD_TYPE = 16'h0010;
  localparam mmio_addr_t MMIO_CMD_ARG0 = 16'h0012;  // Host base
  localparam mmio_addr_t MMIO_CMD_ARG1 = 16'h0014;  // Local base
  localparam mmio_addr_t MMIO_CMD_ARG2 = 16'h0016;  // Line count
  localparam mmio_addr_t MMIO_STATUS   = 16'h0018;

  localparam logic [127:0] AFU_ID = 128'h4c1d7a20_93e64f58_b0a26d3e_915c0f87;

endpackage

/* hw/afu_top.sv */
`timescale 1ns/1ps

module afu_top #(
  parameter int WINDOW     = 8,
  parameter int RD_QUEUE   = 4,
  parameter int WR_PENDING = 16
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      mmio_wr_valid,
  input  logic                      mmio_rd_valid,
  input  afu_pkg::mmio_addr_t       mmio_addr,
  input  logic [63:0]               mmio_wdata,
  input  logic [8:0]                mmio_tid,
  output logic                      mmio_rsp_valid,
  output logic [8:0]                mmio_rsp_tid,
  output logic [63:0]               mmio_rdata,
  output logic                      host_rd_req_valid,
  output afu_pkg::host_addr_t       host_rd_req_addr,
  output logic [$clog2(WINDOW)-1:0] host_rd_req_tag,
  input  logic                      host_rd_almost_full,
  input  logic                      host_rd_rsp_valid,
  input  logic [$clog2(WINDOW)-1:0] host_rd_rsp_tag,
  input  afu_pkg::line_t            host_rd_rsp_data,
  output logic                      host_wr_req_valid,
  output afu_pkg::host_addr_t       host_wr_req_addr,
  output afu_pkg::line_t            host_wr_req_data,
  input  logic                      host_wr_almost_full,
  input  logic                      host_wr_rsp_valid,
  output logic                      mem_read,
  output logic                      mem_write,
  output afu_pkg::lmem_addr_t       mem_address,
  output afu_pkg::line_t            mem_writedata,
  input  logic                      mem_waitrequest,
  input  afu_pkg::line_t            mem_readdata,
  input  logic                      mem_readdatavalid
);
  import afu_pkg::*;

  logic       cmd_start;
  cmd_e       cmd_kind;
  host_addr_t host_base;
  lmem_addr_t lmem_base;
  lmem_addr_t line_count;
  logic       wr_done;
  logic       rd_done;

  lmem_if wr_path ();
  lmem_if rd_path ();

  cmd_ctrl u_ctrl (
    .clk            (clk),
    .reset          (reset),
    .mmio_wr_valid  (mmio_wr_valid),
    .mmio_rd_valid  (mmio_rd_valid),
    .mmio_addr      (mmio_addr),
    .mmio_wdata     (mmio_wdata),
    .mmio_tid       (mmio_tid),
    .wr_done        (wr_done),
    .rd_done        (rd_done),
    .mmio_rsp_valid (mmio_rsp_valid),
    .mmio_rsp_tid   (mmio_rsp_tid),
    .mmio_rdata     (mmio_rdata),
    .state          (),
    .cmd_start      (cmd_start),
    .cmd_kind       (cmd_kind),
    .host_base      (host_base),
    .lmem_base      (lmem_base),
    .line_count     (line_count)
  );

  host_to_local #(.WINDOW (WINDOW)) u_h2l (
    .clk                 (clk),
    .reset               (reset),
    .cmd_start           (cmd_start),
    .cmd_kind            (cmd_kind),
    .host_base           (host_base),
    .lmem_base           (lmem_base),
    .line_count          (line_count),
    .host_rd_almost_full (host_rd_almost_full),
    .host_rd_rsp_valid   (host_rd_rsp_valid),
    .host_rd_rsp_tag     (host_rd_rsp_tag),
    .host_rd_rsp_data    (host_rd_rsp_data),
    .host_rd_req_valid   (host_rd_req_valid),
    .host_rd_req_addr    (host_rd_req_addr),
    .host_rd_req_tag     (host_rd_req_tag),
    .done                (wr_done),
    .lmem                (wr_path)
  );

  local_to_host #(.WR_PENDING (WR_PENDING)) u_l2h (
    .clk                 (clk),
    .reset               (reset),
    .cmd_start           (cmd_start),
    .cmd_kind            (cmd_kind),
    .host_base           (host_base),
    .lmem_base           (lmem_base),
    .line_count          (line_count),
    .host_wr_almost_full (host_wr_almost_full),
    .host_wr_rsp_valid   (host_wr_rsp_valid),
    .host_wr_req_valid   (host_wr_req_valid),
    .host_wr_req_addr    (host_wr_req_addr),
    .host_wr_req_data    (host_wr_req_data),
    .done                (rd_done),
    .lmem                (rd_path)
  );

  lmem_port #(.RD_QUEUE (RD_QUEUE)) u_port (
    .clk               (clk),
    .reset             (reset),
    .mem_waitrequest   (mem_waitrequest),
    .mem_readdata      (mem_readdata),
    .mem_readdatavalid (mem_readdatavalid),
    .mem_read          (mem_read),
    .mem_write         (mem_write),
    .mem_address       (mem_address),
    .mem_writedata     (mem_writedata),
    .wr_path           (wr_path),
    .rd_path           (rd_path)
  );

endmodule

/* hw/cmd_ctrl.sv */
`timescale 1ns/1ps

module cmd_ctrl (
  input  logic                clk,
  input  logic                reset,
  input  logic                mmio_wr_valid,
  input  logic                mmio_rd_valid,
  input  afu_pkg::mmio_addr_t mmio_addr,
  input  logic [63:0]         mmio_wdata,
  input  logic [8:0]          mmio_tid,
  input  logic                wr_done,
  input  logic                rd_done,
  output logic                mmio_rsp_valid,
  output logic [8:0]          mmio_rsp_tid,
  output logic [63:0]         mmio_rdata,
  output afu_pkg::state_e     state,
  output logic                cmd_start,
  output afu_pkg::cmd_e       cmd_kind,
  output afu_pkg::host_addr_t host_base,
  output afu_pkg::lmem_addr_t lmem_base,
  output afu_pkg::lmem_addr_t line_count
);
  import afu_pkg::*;

  logic cmd_wr;

  assign cmd_wr    = mmio_wr_valid && (mmio_addr == MMIO_CMD_TYPE);
  assign cmd_kind  = cmd_e'(mmio_wdata[1:0]);
  // Commands outside idle are dropped
  assign cmd_start = cmd_wr && (state == ST_IDLE)
                     && (cmd_kind == CMD_MEM_READ || cmd_kind == CMD_MEM_WRITE);

  always_ff @(posedge clk) begin
    if (mmio_wr_valid) begin
      case (mmio_addr)
        MMIO_CMD_ARG0: host_base  <= mmio_wdata[31:0];
        MMIO_CMD_ARG1: lmem_base  <= mmio_wdata[15:0];
        MMIO_CMD_ARG2: line_count <= mmio_wdata[15:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset)
      mmio_rsp_valid <= 1'b0;
    else
      mmio_rsp_valid <= mmio_rd_valid;
  end

  always_ff @(posedge clk) begin
    if (mmio_rd_valid) begin
      mmio_rsp_tid <= mmio_tid;
      case (mmio_addr)
        MMIO_AFU_ID_L: mmio_rdata <= AFU_ID[63:0];
        MMIO_AFU_ID_H: mmio_rdata <= AFU_ID[127:64];
        MMIO_STATUS:   mmio_rdata <= 64'(state);
        default:       mmio_rdata <= '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE:      if (cmd_start) state <= state_e'(cmd_kind);
        ST_MEM_READ:  if (rd_done) state <= ST_IDLE;
        ST_MEM_WRITE: if (wr_done) state <= ST_IDLE;
        default:      state <= ST_IDLE;
      endcase
    end
  end

  // Stale done from the last copy would end the new one at once
  assert property (@(posedge clk) disable iff (reset)
    cmd_start |=> ((state == ST_MEM_WRITE) ? !wr_done : !rd_done));

endmodule

/* hw/host_to_local.sv */
`timescale 1ns/1ps

module host_to_local #(
  parameter int WINDOW = 8
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      cmd_start,
  input  afu_pkg::cmd_e             cmd_kind,
  input  afu_pkg::host_addr_t       host_base,
  input  afu_pkg::lmem_addr_t       lmem_base,
  input  afu_pkg::lmem_addr_t       line_count,
  input  logic                      host_rd_almost_full,
  input  logic                      host_rd_rsp_valid,
  input  logic [$clog2(WINDOW)-1:0] host_rd_rsp_tag,
  input  afu_pkg::line_t            host_rd_rsp_data,
  output logic                      host_rd_req_valid,
  output afu_pkg::host_addr_t       host_rd_req_addr,
  output logic [$clog2(WINDOW)-1:0] host_rd_req_tag,
  output logic                      done,
  lmem_if.engine                    lmem
);
  import afu_pkg::*;

  localparam int QDEPTH = 2 * WINDOW;
  localparam int TAGW   = $clog2(WINDOW);
  localparam int PW     = $clog2(QDEPTH + 1);

  logic            start;
  logic            issuing;
  logic            req_wait;    // Window sent, waiting for its responses
  logic            q_pop;
  logic            q_empty;
  logic            q_full;
  logic [TAGW-1:0] rsp_ctr;
  logic [PW-1:0]   pending;
  lmem_addr_t      req_ctr;
  lmem_addr_t      wr_ctr;
  lmem_addr_t      win_base;
  lmem_addr_t      last_idx;
  lmem_addr_t      q_addr;
  line_t           q_data;

  assign start             = cmd_start && (cmd_kind == CMD_MEM_WRITE);
  assign last_idx          = line_count - 16'd1;
  assign host_rd_req_valid = issuing && !req_wait && (pending != PW'(QDEPTH))
                             && !host_rd_almost_full;
  assign host_rd_req_tag   = req_ctr[TAGW-1:0];
  assign q_pop             = lmem.req_valid && lmem.req_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      issuing  <= 1'b0;
      req_wait <= 1'b0;
      rsp_ctr  <= '0;
      pending  <= '0;
      done     <= 1'b0;
    end else begin
      pending <= pending + PW'(host_rd_req_valid) - PW'(q_pop);
      if (start) begin
        issuing  <= 1'b1;
        req_wait <= 1'b0;
        rsp_ctr  <= '0;
        done     <= 1'b0;
      end else begin
        if (host_rd_req_valid && req_ctr == last_idx) issuing <= 1'b0;
        if (host_rd_req_valid && host_rd_req_tag == TAGW'(WINDOW - 1)) req_wait <= 1'b1;
        if (host_rd_rsp_valid) begin
          rsp_ctr <= rsp_ctr + 1'b1;
          if (rsp_ctr == TAGW'(WINDOW - 1)) req_wait <= 1'b0;
        end
        if (q_pop && wr_ctr == last_idx) done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      host_rd_req_addr <= host_base;
      req_ctr          <= '0;
      wr_ctr           <= '0;
      win_base         <= lmem_base;
    end else begin
      if (host_rd_req_valid) begin
        host_rd_req_addr <= host_rd_req_addr + 32'd1;
        req_ctr          <= req_ctr + 16'd1;
      end
      if (host_rd_rsp_valid && rsp_ctr == TAGW'(WINDOW - 1))
        win_base <= win_base + lmem_addr_t'(WINDOW);
      if (q_pop) wr_ctr <= wr_ctr + 16'd1;
    end
  end

  // Reorder queue, each line carries its final local address
  sync_fifo #(
    .DEPTH (QDEPTH),
    .WIDTH ($bits(line_t) + $bits(lmem_addr_t))
  ) u_reorder_q (
    .clk   (clk),
    .reset (reset),
    .push  (host_rd_rsp_valid),
    .pop   (q_pop),
    .din   ({host_rd_rsp_data, win_base + lmem_addr_t'(host_rd_rsp_tag)}),
    .dout  ({q_data, q_addr}),
    .empty (q_empty),
    .full  (q_full)
  );

  assign lmem.req_valid = !q_empty;
  assign lmem.req_rw    = 1'b1;
  assign lmem.req_addr  = q_addr;
  assign lmem.req_data  = q_data;
  assign lmem.req_tag   = wr_ctr;
  assign lmem.rsp_ready = 1'b1;

  // Pending limit must keep host responses from overrunning the queue
  assert property (@(posedge clk) disable iff (reset) host_rd_rsp_valid |-> !q_full);

endmodule

/* hw/lmem_if.sv */
`timescale 1ns/1ps

interface lmem_if;
  import afu_pkg::*;

  logic       req_valid;
  logic       req_rw;     // 1 = write
  lmem_addr_t req_addr;
  line_t      req_data;
  lmem_addr_t req_tag;
  logic       req_ready;

  logic       rsp_valid;
  line_t      rsp_data;
  lmem_addr_t rsp_tag;
  logic       rsp_ready;

  modport engine (
    output req_valid, req_rw, req_addr, req_data, req_tag, rsp_ready,
    input  req_ready, rsp_valid, rsp_data, rsp_tag
  );

  modport port (
    input  req_valid, req_rw, req_addr, req_data, req_tag, rsp_ready,
    output req_ready, rsp_valid, rsp_data, rsp_tag
  );

endinterface

/* hw/lmem_port.sv */
`timescale 1ns/1ps

module lmem_port #(
  parameter int RD_QUEUE = 4
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                mem_waitrequest,
  input  afu_pkg::line_t      mem_readdata,
  input  logic                mem_readdatavalid,
  output logic                mem_read,
  output logic                mem_write,
  output afu_pkg::lmem_addr_t mem_address,
  output afu_pkg::line_t      mem_writedata,
  lmem_if.port                wr_path,
  lmem_if.port                rd_path
);
  import afu_pkg::*;

  logic tq_full;
  logic tq_empty;
  logic dq_empty;
  logic rsp_fire;

  // Writes win, reads wait for a free tag slot
  assign mem_write     = wr_path.req_valid && wr_path.req_rw;
  assign mem_read      = !mem_write && rd_path.req_valid && !rd_path.req_rw && !tq_full;
  assign mem_address   = mem_write ? wr_path.req_addr : rd_path.req_addr;
  assign mem_writedata = wr_path.req_data;

  assign wr_path.req_ready = !mem_waitrequest;
  assign wr_path.rsp_valid = 1'b0;  // Writes are not answered
  assign wr_path.rsp_data  = '0;
  assign wr_path.rsp_tag   = '0;

  assign rd_path.req_ready = !mem_waitrequest && !mem_write && !tq_full;
  assign rd_path.rsp_valid = !dq_empty;
  assign rsp_fire          = rd_path.rsp_valid && rd_path.rsp_ready;

  // Tag stays queued until its line is taken, so at most RD_QUEUE lines are held
  sync_fifo #(
    .DEPTH (RD_QUEUE),
    .WIDTH ($bits(lmem_addr_t))
  ) u_tag_q (
    .clk   (clk),
    .reset (reset),
    .push  (mem_read && !mem_waitrequest),
    .pop   (rsp_fire),
    .din   (rd_path.req_tag),
    .dout  (rd_path.rsp_tag),
    .empty (tq_empty),
    .full  (tq_full)
  );

  // Return data buffer
  sync_fifo #(
    .DEPTH (RD_QUEUE),
    .WIDTH ($bits(line_t))
  ) u_data_q (
    .clk   (clk),
    .reset (reset),
    .push  (mem_readdatavalid),
    .pop   (rsp_fire),
    .din   (mem_readdata),
    .dout  (rd_path.rsp_data),
    .empty (dq_empty),
    .full  ()
  );

  assert property (@(posedge clk) disable iff (reset) mem_readdatavalid |-> !tq_empty);

endmodule

/* hw/local_to_host.sv */
`timescale 1ns/1ps

module local_to_host #(
  parameter int WR_PENDING = 16
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                cmd_start,
  input  afu_pkg::cmd_e       cmd_kind,
  input  afu_pkg::host_addr_t host_base,
  input  afu_pkg::lmem_addr_t lmem_base,
  input  afu_pkg::lmem_addr_t line_count,
  input  logic                host_wr_almost_full,
  input  logic                host_wr_rsp_valid,
  output logic                host_wr_req_valid,
  output afu_pkg::host_addr_t host_wr_req_addr,
  output afu_pkg::line_t      host_wr_req_data,
  output logic                done,
  lmem_if.engine              lmem
);
  import afu_pkg::*;

  localparam int PW = $clog2(WR_PENDING + 1);

  logic          start;
  logic          reading;
  logic          rd_fire;
  logic          rsp_fire;
  logic [PW-1:0] pending;  // Unacknowledged host writes
  lmem_addr_t    rd_ctr;
  lmem_addr_t    wr_left;
  lmem_addr_t    last_idx;

  assign start    = cmd_start && (cmd_kind == CMD_MEM_READ);
  assign last_idx = line_count - 16'd1;
  assign rd_fire  = lmem.req_valid && lmem.req_ready;
  assign rsp_fire = lmem.rsp_valid && lmem.rsp_ready;
  assign done     = (wr_left == '0) && (pending == '0);

  assign lmem.req_valid = reading;
  assign lmem.req_rw    = 1'b0;
  assign lmem.req_addr  = lmem_base + rd_ctr;
  assign lmem.req_data  = '0;
  assign lmem.req_tag   = rd_ctr;  // Line index
  assign lmem.rsp_ready = !host_wr_almost_full && (pending != PW'(WR_PENDING));

  always_ff @(posedge clk) begin
    if (reset) begin
      reading           <= 1'b0;
      host_wr_req_valid <= 1'b0;
      pending           <= '0;
      wr_left           <= '0;
    end else begin
      host_wr_req_valid <= rsp_fire;
      pending <= pending + PW'(rsp_fire) - PW'(host_wr_rsp_valid);
      if (start) begin
        reading <= 1'b1;
        wr_left <= line_count;
      end else begin
        if (rd_fire && rd_ctr == last_idx) reading <= 1'b0;
        if (host_wr_req_valid) wr_left <= wr_left - 16'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start)
      rd_ctr <= '0;
    else if (rd_fire)
      rd_ctr <= rd_ctr + 16'd1;
    host_wr_req_addr <= host_base + host_addr_t'(lmem.rsp_tag);
    host_wr_req_data <= lmem.rsp_data;
  end

  assert property (@(posedge clk) disable iff (reset) host_wr_rsp_valid |-> pending != '0);

endmodule

/* hw/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
  parameter int DEPTH = 4,
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             push,
  input  logic             pop,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout,
  output logic             empty,
  output logic             full
);
  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    rd_ptr;
  logic [AW-1:0]    wr_ptr;
  logic [AW:0]      count;
  logic             do_push;
  logic             do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;
  assign empty   = (count == '0);
  assign full    = (count == (AW+1)'(DEPTH));
  assign dout    = mem[rd_ptr];  // First word falls through

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push)
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + (AW+1)'(do_push) - (AW+1)'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= din;
  end

endmodule

/* list.f */
hw/afu_pkg.sv
hw/lmem_if.sv
hw/sync_fifo.sv
hw/cmd_ctrl.sv
hw/host_to_local.sv
hw/local_to_host.sv
hw/lmem_port.sv
hw/afu_top.sv
tests/tb_afu.sv

/* tests/tb_afu.sv */
`timescale 1ns/1ps

module tb_afu;
  import afu_pkg::*;

  localparam int WINDOW         = 8;
  localparam int TAG_W          = $clog2(WINDOW);
  localparam int MEM_LINES      = 256;
  localparam int RESET_CYCLES   = 16;
  localparam int SHORT_LINES    = 13;
  localparam int LONG_LINES     = 40;
  localparam int TIMEOUT_CYCLES = 200 * (2 * SHORT_LINES + 2 * LONG_LINES) + RESET_CYCLES;

  logic             clk = 1'b0;
  logic             reset;
  logic             mmio_wr_valid;
  logic             mmio_rd_valid;
  mmio_addr_t       mmio_addr;
  logic [63:0]      mmio_wdata;
  logic [8:0]       mmio_tid;
  logic             mmio_rsp_valid;
  logic [8:0]       mmio_rsp_tid;
  logic [63:0]      mmio_rdata;
  logic             host_rd_req_valid;
  host_addr_t       host_rd_req_addr;
  logic [TAG_W-1:0] host_rd_req_tag;
  logic             host_rd_almost_full;
  logic             host_rd_rsp_valid;
  logic [TAG_W-1:0] host_rd_rsp_tag;
  line_t            host_rd_rsp_data;
  logic             host_wr_req_valid;
  host_addr_t       host_wr_req_addr;
  line_t            host_wr_req_data;
  logic             host_wr_almost_full;
  logic             host_wr_rsp_valid;
  logic             mem_read;
  logic             mem_write;
  lmem_addr_t       mem_address;
  line_t            mem_writedata;
  logic             mem_waitrequest;
  line_t            mem_readdata;
  logic             mem_readdatavalid;

  line_t       host_init [MEM_LINES];  // Host contents before any copy
  line_t       host_mem [MEM_LINES];
  line_t       local_mem [MEM_LINES];
  logic [31:0] rng_state = 32'd53;
  bit          stress;
  int          cyc;
  logic [8:0]  next_tid;

  // Commands the DUT accepted, in order
  cmd_e log_kind [8];
  int   log_hb [8];
  int   log_lb [8];
  int   log_n [8];
  int   num_cmds;

  afu_top #(
    .WINDOW     (WINDOW),
    .RD_QUEUE   (4),
    .WR_PENDING (16)
  ) UUT (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic line_t local_fill(input int addr);
    return {16'h1ca1, 16'(addr), ~16'(addr), 16'(addr) ^ 16'h5a5a};
  endfunction

  // Walks the copy history backward to the line's original source
  function automatic line_t expected_line(input bit in_host, input int addr);
    bit on_host;
    int a;
    int k;
    on_host = in_host;
    a = addr;
    for (k = num_cmds - 1; k >= 0; k--) begin
      if (log_kind[k] == CMD_MEM_WRITE && !on_host && a >= log_lb[k]
          && a < log_lb[k] + log_n[k]) begin
        on_host = 1'b1;
        a = log_hb[k] + (a - log_lb[k]);
      end else if (log_kind[k] == CMD_MEM_READ && on_host && a >= log_hb[k]
                   && a < log_hb[k] + log_n[k]) begin
        on_host = 1'b0;
        a = log_lb[k] + (a - log_hb[k]);
      end
    end
    if (on_host)
      return host_init[a];
    else
      return local_fill(a);
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected)
      stop_with_failure($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
  endtask

  task automatic mmio_write(input mmio_addr_t addr, input logic [63:0] data);
    @(negedge clk);
    mmio_wr_valid = 1'b1;
    mmio_addr     = addr;
    mmio_wdata    = data;
    @(negedge clk);
    mmio_wr_valid = 1'b0;
  endtask

  task automatic mmio_read(input mmio_addr_t addr, output logic [63:0] data);
    logic [8:0] tid;
    tid = next_tid;
    next_tid = next_tid + 9'd37;
    @(negedge clk);
    check_value("mmio response idle before read", 64'd0, 64'(mmio_rsp_valid));
    mmio_rd_valid = 1'b1;
    mmio_addr     = addr;
    mmio_tid      = tid;
    @(negedge clk);
    mmio_rd_valid = 1'b0;
    check_value("mmio response one cycle after read", 64'd1, 64'(mmio_rsp_valid));
    check_value("mmio response tid", 64'(tid), 64'(mmio_rsp_tid));
    data = mmio_rdata;
    @(negedge clk);
    check_value("mmio response single cycle", 64'd0, 64'(mmio_rsp_valid));
  endtask

  task automatic check_memories(input string test);
    int i;
    for (i = 0; i < MEM_LINES; i++) begin
      check_value($sformatf("%s host[%0d]", test, i), expected_line(1'b1, i), host_mem[i]);
      check_value($sformatf("%s local[%0d]", test, i), expected_line(1'b0, i), local_mem[i]);
    end
  endtask

  task automatic run_copy(input string test, input cmd_e kind, input int hb, input int lb,
                          input int n, input bit busy_cmd);
    logic [63:0] status;
    state_e      busy_state;
    cmd_e        other;
    busy_state = (kind == CMD_MEM_WRITE) ? ST_MEM_WRITE : ST_MEM_READ;
    other      = (kind == CMD_MEM_WRITE) ? CMD_MEM_READ : CMD_MEM_WRITE;
    mmio_write(MMIO_CMD_ARG0, 64'(hb));
    mmio_write(MMIO_CMD_ARG1, 64'(lb));
    mmio_write(MMIO_CMD_ARG2, 64'(n));
    mmio_write(MMIO_CMD_TYPE, 64'(kind));
    log_kind[num_cmds] = kind;
    log_hb[num_cmds]   = hb;
    log_lb[num_cmds]   = lb;
    log_n[num_cmds]    = n;
    num_cmds = num_cmds + 1;
    mmio_read(MMIO_STATUS, status);
    check_value({test, " busy status"}, 64'(busy_state), status);
    if (busy_cmd) begin
      mmio_write(MMIO_CMD_TYPE, 64'(other));  // Must be dropped
      mmio_read(MMIO_STATUS, status);
      check_value({test, " status after busy command"}, 64'(busy_state), status);
    end
    do
      mmio_read(MMIO_STATUS, status);
    while (status != 64'd0);
    check_memories(test);
  endtask

  // Host and local memory models
  initial begin
    logic [31:0] r;
    logic [31:0] hi;
    logic [31:0] lo;
    int          j;
    int          pick;
    bit          bad;
    host_addr_t  a_tmp;
    line_t       rd_data_q [$];
    int          rd_due_q [$];
    host_addr_t  hr_addr [$];
    logic [TAG_W-1:0] hr_tag [$];
    int          hr_due [$];
    int          ack_due [$];

    cyc = 0;
    host_rd_almost_full = 1'b0;
    host_rd_rsp_valid   = 1'b0;
    host_rd_rsp_tag     = '0;
    host_rd_rsp_data    = '0;
    host_wr_almost_full = 1'b0;
    host_wr_rsp_valid   = 1'b0;
    mem_waitrequest     = 1'b0;
    mem_readdata        = '0;
    mem_readdatavalid   = 1'b0;
    for (j = 0; j < MEM_LINES; j++) begin
      hi = next_random();
      lo = next_random();
      host_init[j] = {hi, lo};
      host_mem[j]  = {hi, lo};
      local_mem[j] = local_fill(j);
    end

    forever begin
      @(posedge clk);
      cyc = cyc + 1;
      bad = ((mem_write || mem_read) && !mem_waitrequest && mem_address > 16'd255)
            || (host_rd_req_valid && host_rd_req_addr > 32'd255)
            || (host_wr_req_valid && host_wr_req_addr > 32'd255);
      if (cyc > TIMEOUT_CYCLES) begin
        stop_with_failure($sformatf("Timeout after %0d cycles, copy never finished", cyc));
      end else if (!reset && bad) begin
        stop_with_failure("Memory access outside the modeled address range");
      end else if (!reset) begin
        if (mem_write && !mem_waitrequest)
          local_mem[mem_address[7:0]] = mem_writedata;
        if (mem_read && !mem_waitrequest) begin
          rd_data_q.push_back(local_mem[mem_address[7:0]]);
          rd_due_q.push_back(cyc + 2);  // Fixed two-cycle latency
        end
        if (host_rd_req_valid) begin
          r = next_random();
          hr_addr.push_back(host_rd_req_addr);
          hr_tag.push_back(host_rd_req_tag);
          hr_due.push_back(cyc + 1 + int'(r % 32'd12));
        end
        if (host_wr_req_valid) begin
          r = next_random();
          host_mem[host_wr_req_addr[7:0]] = host_wr_req_data;
          ack_due.push_back(cyc + 1 + int'(r % 32'd8));
        end
      end

      @(negedge clk);
      r = next_random();
      mem_waitrequest     = stress && (r[1:0] == 2'b00);
      host_rd_almost_full = stress && (r[3:2] == 2'b00);
      host_wr_almost_full = stress && (r[5:4] == 2'b00);

      mem_readdatavalid = 1'b0;
      mem_readdata      = '0;
      if (rd_due_q.size() > 0 && rd_due_q[0] == cyc + 1) begin
        mem_readdatavalid = 1'b1;
        mem_readdata      = rd_data_q.pop_front();
        void'(rd_due_q.pop_front());
      end

      // Earliest due response goes first, so random delays reorder them
      host_rd_rsp_valid = 1'b0;
      pick = -1;
      for (j = 0; j < hr_due.size(); j++) begin
        if (hr_due[j] <= cyc + 1 && (pick < 0 || hr_due[j] < hr_due[pick]))
          pick = j;
      end
      if (pick >= 0) begin
        a_tmp = hr_addr[pick];
        host_rd_rsp_valid = 1'b1;
        host_rd_rsp_tag   = hr_tag[pick];
        host_rd_rsp_data  = host_mem[a_tmp[7:0]];
        hr_addr.delete(pick);
        hr_tag.delete(pick);
        hr_due.delete(pick);
      end

      host_wr_rsp_valid = 1'b0;
      pick = -1;
      for (j = 0; j < ack_due.size(); j++) begin
        if (pick < 0 && ack_due[j] <= cyc + 1)
          pick = j;
      end
      if (pick >= 0) begin
        host_wr_rsp_valid = 1'b1;
        ack_due.delete(pick);
      end
    end
  end

  initial begin
    logic [63:0] rdata;
    reset         = 1'b1;
    mmio_wr_valid = 1'b0;
    mmio_rd_valid = 1'b0;
    mmio_addr     = '0;
    mmio_wdata    = '0;
    mmio_tid      = '0;
    stress        = 1'b0;
    num_cmds      = 0;
    next_tid      = 9'h05;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    check_value("reset host_rd_req_valid", 64'd0, 64'(host_rd_req_valid));
    check_value("reset host_wr_req_valid", 64'd0, 64'(host_wr_req_valid));
    check_value("reset mem_read", 64'd0, 64'(mem_read));
    check_value("reset mem_write", 64'd0, 64'(mem_write));
    check_value("reset mmio_rsp_valid", 64'd0, 64'(mmio_rsp_valid));
    mmio_read(MMIO_STATUS, rdata);
    check_value("reset status", 64'd0, rdata);
    mmio_read(MMIO_AFU_ID_L, rdata);
    check_value("afu id low", AFU_ID[63:0], rdata);
    mmio_read(MMIO_AFU_ID_H, rdata);
    check_value("afu id high", AFU_ID[127:64], rdata);

    run_copy("mem_write_13", CMD_MEM_WRITE, 32, 16, SHORT_LINES, 1'b0);
    run_copy("mem_read_13", CMD_MEM_READ, 96, 16, SHORT_LINES, 1'b0);

    @(posedge clk);
    stress = 1'b1;  // Waitrequest and almost full from here on
    run_copy("stress_mem_write_40", CMD_MEM_WRITE, 144, 64, LONG_LINES, 1'b1);
    run_copy("stress_mem_read_40", CMD_MEM_READ, 192, 64, LONG_LINES, 1'b0);

    $display("TEST PASS");
    $finish;
  end

endmodule
